/* mem_frontend.f */
design/mem_frontend_pkg.sv
design/seg_translate.sv
design/uncached_port.sv
design/axi_arbiter_2x1.sv
design/mem_frontend_top.sv
bench/axi_slave_model.sv
bench/mem_frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= mem_frontend_tb
FILELIST  ?= mem_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/mem_frontend_tb.sv */
`default_nettype none

module mem_frontend_tb;

	localparam int CLK_PERIOD = 8;
	localparam int N_TESTS    = 6;
	localparam int N_RANDOM   = 32;

	logic                          aclk = 1'b0;
	logic                          i_arst_n;
	mem_frontend_pkg::sram_req_t   inst_req;
	mem_frontend_pkg::sram_req_t   data_req;
	mem_frontend_pkg::sram_req_t   idle_req;
	logic [31:0]                   inst_rdata;
	logic [31:0]                   data_rdata;
	logic                          inst_stall;
	logic                          data_stall;
	logic                          inst_fault;
	logic                          data_fault;
	mem_frontend_pkg::axi_addr_t   ar;
	mem_frontend_pkg::axi_addr_t   aw;
	mem_frontend_pkg::axi_wdata_t  w;
	logic                          arvalid;
	logic                          rready;
	logic                          awvalid;
	logic                          wvalid;
	logic                          bready;
	logic                          arready;
	logic                          awready;
	logic                          wready;
	logic                          rvalid;
	logic                          bvalid;
	logic [31:0]                   rdata;

	int          errors = 0;
	int          mark = 0;
	int unsigned seed_ret;
	logic [31:0] addr_seen [$];  // AR and AW handshakes in order
	logic [2:0]  size_seen [$];
	logic [3:0]  strb_seen [$];
	logic [31:0] shadow [logic [29:0]];

	// previous-cycle values for the stability and stall monitors
	logic                          ar_v_q = 1'b0;
	logic                          ar_r_q = 1'b0;
	logic                          aw_v_q = 1'b0;
	logic                          aw_r_q = 1'b0;
	logic                          w_v_q = 1'b0;
	logic                          w_r_q = 1'b0;
	mem_frontend_pkg::axi_addr_t   ar_q;
	mem_frontend_pkg::axi_addr_t   aw_q;
	mem_frontend_pkg::axi_wdata_t  w_q;
	logic                          i_stall_q = 1'b0;
	logic                          d_stall_q = 1'b0;
	logic                          i_done_q = 1'b0;
	logic                          d_done_q = 1'b0;

	always #(CLK_PERIOD / 2) aclk = ~aclk;

	mem_frontend_top mem_frontend_top_i (
		.aclk         (aclk),
		.i_arst_n     (i_arst_n),
		.i_inst_req   (inst_req),
		.i_data_req   (data_req),
		.i_arready    (arready),
		.i_awready    (awready),
		.i_wready     (wready),
		.i_rdata      (rdata),
		.i_rvalid     (rvalid),
		.i_bvalid     (bvalid),
		.o_inst_rdata (inst_rdata),
		.o_data_rdata (data_rdata),
		.o_inst_stall (inst_stall),
		.o_data_stall (data_stall),
		.o_inst_fault (inst_fault),
		.o_data_fault (data_fault),
		.o_ar         (ar),
		.o_arvalid    (arvalid),
		.o_rready     (rready),
		.o_aw         (aw),
		.o_awvalid    (awvalid),
		.o_w          (w),
		.o_wvalid     (wvalid),
		.o_bready     (bready)
	);

	axi_slave_model u_slave (
		.aclk      (aclk),
		.i_arst_n  (i_arst_n),
		.i_ar      (ar),
		.i_arvalid (arvalid),
		.i_rready  (rready),
		.i_aw      (aw),
		.i_awvalid (awvalid),
		.i_w       (w),
		.i_wvalid  (wvalid),
		.i_bready  (bready),
		.o_arready (arready),
		.o_awready (awready),
		.o_wready  (wready),
		.o_rdata   (rdata),
		.o_rvalid  (rvalid),
		.o_bvalid  (bvalid)
	);

	function automatic logic [31:0] pattern_at(input logic [31:0] addr);
		return {addr[17:2], addr[31:18], 2'b10} ^ 32'h5ac3_3ca5;
	endfunction

	// kseg0 and kseg1 lose their top three bits
	function automatic logic [31:0] to_phys(input logic [31:0] addr);
		if (addr >= 32'h8000_0000 && addr <= 32'hbfff_ffff) return {3'b000, addr[28:0]};
		return addr;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] phys);
		if (shadow.exists(phys[31:2])) return shadow[phys[31:2]];
		return pattern_at(phys);
	endfunction

	function automatic logic [31:0] pick_addr(input logic [7:0] bits);
		logic [31:0] base;
		case (bits[1:0])
			2'd0:    base = 32'h0000_0000;
			2'd1:    base = 32'h8000_0000;
			2'd2:    base = 32'ha000_0000;
			default: base = 32'h2000_0000;  // kuseg passes through
		endcase
		return base | {24'd0, bits[7:2], 2'b00};
	endfunction

	function automatic mem_frontend_pkg::sram_req_t make_req(
		input logic [3:0]              wen,
		input mem_frontend_pkg::size_e size,
		input logic [31:0]             addr,
		input logic [31:0]             wdata
	);
		mem_frontend_pkg::sram_req_t r;
		r.en    = 1'b1;
		r.wen   = wen;
		r.size  = size;
		r.addr  = addr;
		r.wdata = wdata;
		return r;
	endfunction

	task automatic shadow_write(input logic [31:0] phys, input logic [31:0] data,
	                            input logic [3:0] strb);
		logic [31:0] word;
		word = expected_word(phys);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
		end
		shadow[phys[31:2]] = word;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d (%s) finished with %0d errors", num, name, errors - mark);
		mark = errors;
	endtask

	task automatic check_idle();
		check_value("{arvalid,awvalid,wvalid,rready,bready,stalls,faults}",
		            32'({arvalid, awvalid, wvalid, rready, bready,
		                 inst_stall, data_stall, inst_fault, data_fault}), 32'd0);
	endtask

	// drive both ports at a falling edge and drop each en as its stall falls
	task automatic run_pair(input mem_frontend_pkg::sram_req_t ireq,
	                        input mem_frontend_pkg::sram_req_t dreq,
	                        output logic [31:0] irdata, output logic [31:0] drdata);
		logic ipend;
		logic dpend;
		int   cycles;
		ipend    = ireq.en;
		dpend    = dreq.en;
		cycles   = 0;
		irdata   = '0;
		drdata   = '0;
		inst_req = ireq;
		data_req = dreq;
		while ((ipend || dpend) && cycles < 64) begin
			@(negedge aclk);
			cycles++;
			if (dpend && !data_stall) begin
				drdata      = data_rdata;
				data_req.en = 1'b0;
				dpend       = 1'b0;
			end
			if (ipend && !inst_stall) begin
				irdata      = inst_rdata;
				inst_req.en = 1'b0;
				ipend       = 1'b0;
			end
		end
		if (ipend || dpend) note_failure("access did not complete within 64 cycles");
	endtask

	task automatic hold_fault(input mem_frontend_pkg::sram_req_t req);
		data_req = req;
		repeat (4) begin
			@(negedge aclk);
			check_value("o_data_fault", 32'(data_fault), 32'd1);
			check_value("o_data_stall", 32'(data_stall), 32'd0);
			check_value("o_arvalid|o_awvalid", 32'(arvalid | awvalid), 32'd0);
		end
	endtask

	// channel stability, handshake log and the one-cycle stall drop
	always @(posedge aclk) begin
		if (i_arst_n) begin
			if (ar_v_q && !ar_r_q) begin
				check_value("o_arvalid", 32'(arvalid), 32'd1);
				check_value("o_ar.addr", ar.addr, ar_q.addr);
				check_value("o_ar.size", 32'(ar.size), 32'(ar_q.size));
			end
			if (aw_v_q && !aw_r_q) begin
				check_value("o_awvalid", 32'(awvalid), 32'd1);
				check_value("o_aw.addr", aw.addr, aw_q.addr);
				check_value("o_aw.size", 32'(aw.size), 32'(aw_q.size));
			end
			if (w_v_q && !w_r_q) begin
				check_value("o_wvalid", 32'(wvalid), 32'd1);
				check_value("o_w.data", w.data, w_q.data);
				check_value("o_w.strb", 32'(w.strb), 32'(w_q.strb));
			end
			if (arvalid && arready) begin
				addr_seen.push_back(ar.addr);
				size_seen.push_back(ar.size);
			end
			if (awvalid && awready) begin
				addr_seen.push_back(aw.addr);
				size_seen.push_back(aw.size);
			end
			if (wvalid && wready) strb_seen.push_back(w.strb);
			// next request held after a finish must stall again
			if (i_done_q && inst_req.en && !inst_fault) begin
				check_value("o_inst_stall", 32'(inst_stall), 32'd1);
			end
			if (d_done_q && data_req.en && !data_fault) begin
				check_value("o_data_stall", 32'(data_stall), 32'd1);
			end
		end
		i_done_q  = i_stall_q && !inst_stall && inst_req.en && !inst_fault;
		d_done_q  = d_stall_q && !data_stall && data_req.en && !data_fault;
		i_stall_q = inst_stall;
		d_stall_q = data_stall;
		ar_v_q    = arvalid;
		ar_r_q    = arready;
		aw_v_q    = awvalid;
		aw_r_q    = awready;
		w_v_q     = wvalid;
		w_r_q     = wready;
		ar_q      = ar;
		aw_q      = aw;
		w_q       = w;
	end

	initial begin
		logic [31:0] ird;
		logic [31:0] drd;
		logic [31:0] rnd;
		logic [31:0] daddr;
		logic [31:0] iaddr;
		logic [31:0] wdata;
		logic [31:0] dexp;
		logic [31:0] iexp;
		logic [3:0]  dwen;
		seed_ret = $urandom(32'hb105a38b);
		idle_req = '0;
		inst_req = '0;
		data_req = '0;
		i_arst_n = 1'b0;

		repeat (5) begin
			@(negedge aclk);
			check_idle();
		end
		i_arst_n = 1'b1;
		@(negedge aclk);
		check_idle();
		finish_test(1, "reset");

		addr_seen.delete();
		size_seen.delete();
		run_pair(make_req(4'h0, mem_frontend_pkg::SIZE_WORD, 32'h8000_0240, '0),
		         idle_req, ird, drd);
		check_value("AR count", 32'(addr_seen.size()), 32'd1);
		check_value("o_ar.addr", addr_seen[0], 32'h0000_0240);
		check_value("o_ar.size", 32'(size_seen[0]), 32'd2);
		check_value("o_inst_rdata", ird, expected_word(32'h0000_0240));
		// back to back fetch from kseg1
		run_pair(make_req(4'h0, mem_frontend_pkg::SIZE_WORD, 32'ha000_0244, '0),
		         idle_req, ird, drd);
		check_value("second o_ar.addr", addr_seen[1], 32'h0000_0244);
		check_value("o_inst_rdata", ird, expected_word(32'h0000_0244));
		finish_test(2, "translated read");

		addr_seen.delete();
		strb_seen.delete();
		run_pair(idle_req, make_req(4'b0110, mem_frontend_pkg::SIZE_WORD, 32'ha000_0104,
		         32'h1122_3344), ird, drd);
		shadow_write(32'h0000_0104, 32'h1122_3344, 4'b0110);
		check_value("AW count", 32'(addr_seen.size()), 32'd1);
		check_value("o_aw.addr", addr_seen[0], 32'h0000_0104);
		check_value("o_w.strb", 32'(strb_seen[0]), 32'b0110);
		run_pair(idle_req, make_req(4'h0, mem_frontend_pkg::SIZE_WORD, 32'h8000_0104, '0),
		         ird, drd);
		check_value("o_data_rdata", drd, expected_word(32'h0000_0104));
		finish_test(3, "strobed write and read-back");

		addr_seen.delete();
		hold_fault(make_req(4'h0, mem_frontend_pkg::SIZE_HALF, 32'h0000_0105, '0));
		hold_fault(make_req(4'hf, mem_frontend_pkg::SIZE_WORD, 32'h0000_0106, 32'hdead_beef));
		data_req.en = 1'b0;
		check_value("AR/AW count", 32'(addr_seen.size()), 32'd0);
		finish_test(4, "alignment fault");

		addr_seen.delete();
		run_pair(make_req(4'h0, mem_frontend_pkg::SIZE_WORD, 32'h8000_0300, '0),
		         make_req(4'h0, mem_frontend_pkg::SIZE_WORD, 32'h0000_0080, '0), ird, drd);
		check_value("AR count", 32'(addr_seen.size()), 32'd2);
		check_value("first o_ar.addr", addr_seen[0], 32'h0000_0080);
		check_value("second o_ar.addr", addr_seen[1], 32'h0000_0300);
		check_value("o_data_rdata", drd, expected_word(32'h0000_0080));
		check_value("o_inst_rdata", ird, expected_word(32'h0000_0300));
		finish_test(5, "priority");

		for (int n = 0; n < N_RANDOM; n++) begin
			rnd   = $urandom;
			wdata = $urandom;
			daddr = pick_addr(rnd[7:0]);
			iaddr = pick_addr(rnd[23:16]);
			dwen  = rnd[8] ? rnd[12:9] : 4'h0;
			dexp  = expected_word(to_phys(daddr));
			if (dwen != 4'h0) shadow_write(to_phys(daddr), wdata, dwen);
			iexp  = expected_word(to_phys(iaddr));  // data goes first
			if (rnd[13]) begin
				@(negedge aclk);  // both ports idle so they raise valid together
				run_pair(make_req(4'h0, mem_frontend_pkg::SIZE_WORD, iaddr, '0),
				         make_req(dwen, mem_frontend_pkg::SIZE_WORD, daddr, wdata), ird, drd);
				check_value("o_inst_rdata", ird, iexp);
			end else begin
				run_pair(idle_req, make_req(dwen, mem_frontend_pkg::SIZE_WORD, daddr, wdata),
				         ird, drd);
			end
			if (dwen == 4'h0) check_value("o_data_rdata", drd, dexp);
		end
		finish_test(6, "back-pressure");

		$display("%0d tests run, %0d checks failed", N_TESTS, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// bounds the run at 200 cycles per test
	initial begin
		#(N_TESTS * 200 * CLK_PERIOD);
		$display("Error: watchdog expired after %0d cycles", N_TESTS * 200);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/axi_slave_model.sv */
`default_nettype none

module axi_slave_model (
	input  wire                                 aclk,
	input  wire                                 i_arst_n,
	input  wire  mem_frontend_pkg::axi_addr_t   i_ar,
	input  wire                                 i_arvalid,
	input  wire                                 i_rready,
	input  wire  mem_frontend_pkg::axi_addr_t   i_aw,
	input  wire                                 i_awvalid,
	input  wire  mem_frontend_pkg::axi_wdata_t  i_w,
	input  wire                                 i_wvalid,
	input  wire                                 i_bready,
	output logic                                o_arready,
	output logic                                o_awready,
	output logic                                o_wready,
	output logic [mem_frontend_pkg::DATA_W-1:0] o_rdata,
	output logic                                o_rvalid,
	output logic                                o_bvalid
);

	logic [31:0] mem [logic [29:0]];  // written words only
	int unsigned ar_cnt;
	int unsigned r_cnt;
	int unsigned aw_cnt;
	int unsigned w_cnt;
	int unsigned b_cnt;
	logic        ar_fire;
	logic        r_fire;
	logic        aw_fire;
	logic        w_fire;
	logic        b_fire;
	logic        rd_pend;
	logic        aw_got;
	logic        w_got;
	logic [31:0] rd_addr;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;

	// preset contents, a function of the word address
	function automatic logic [31:0] preset_word(input logic [31:0] addr);
		return {addr[17:2], addr[31:18], 2'b10} ^ 32'h5ac3_3ca5;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (mem.exists(addr[31:2])) begin
			return mem[addr[31:2]];
		end
		return preset_word(addr);
	endfunction

	function automatic int unsigned draw_delay();
		return $urandom_range(3, 0);
	endfunction

	task automatic clear_all();
		o_arready = 1'b0;
		o_awready = 1'b0;
		o_wready  = 1'b0;
		o_rvalid  = 1'b0;
		o_bvalid  = 1'b0;
		o_rdata   = '0;
		{ar_fire, r_fire, aw_fire, w_fire, b_fire} = '0;
		{rd_pend, aw_got, w_got} = '0;
		ar_cnt = draw_delay();
		r_cnt  = draw_delay();
		aw_cnt = draw_delay();
		w_cnt  = draw_delay();
		b_cnt  = draw_delay();
	endtask

	// handshakes seen here happened at the rising edge just passed
	task automatic step();
		logic [31:0] word;
		if (r_fire) begin
			o_rvalid = 1'b0;
			rd_pend  = 1'b0;
		end
		if (ar_fire) begin
			o_arready = 1'b0;
			rd_pend   = 1'b1;
			ar_cnt    = draw_delay();
			r_cnt     = draw_delay();
		end else if (i_arvalid && !o_arready && !rd_pend) begin
			if (ar_cnt == 0) o_arready = 1'b1;
			else ar_cnt--;
		end
		if (rd_pend && !o_rvalid) begin
			if (r_cnt == 0) begin
				o_rvalid = 1'b1;
				o_rdata  = read_word(rd_addr);
			end else begin
				r_cnt--;
			end
		end
		ar_fire = i_arvalid && o_arready;
		if (ar_fire) rd_addr = i_ar.addr;
		r_fire = o_rvalid && i_rready;

		if (b_fire) begin
			o_bvalid = 1'b0;
			aw_got   = 1'b0;
			w_got    = 1'b0;
		end
		if (aw_fire) begin
			o_awready = 1'b0;
			aw_got    = 1'b1;
			aw_cnt    = draw_delay();
		end else if (i_awvalid && !o_awready && !aw_got) begin
			if (aw_cnt == 0) o_awready = 1'b1;
			else aw_cnt--;
		end
		if (w_fire) begin
			o_wready = 1'b0;
			w_got    = 1'b1;
			w_cnt    = draw_delay();
		end else if (i_wvalid && !o_wready && !w_got) begin
			if (w_cnt == 0) o_wready = 1'b1;
			else w_cnt--;
		end
		if (aw_got && w_got && !o_bvalid && !b_fire) begin
			if (b_cnt == 0) begin
				word = read_word(wr_addr);
				for (int b = 0; b < 4; b++) begin
					if (wr_strb[b]) word[8*b +: 8] = wr_data[8*b +: 8];
				end
				mem[wr_addr[31:2]] = word;
				o_bvalid = 1'b1;
				b_cnt    = draw_delay();
			end else begin
				b_cnt--;
			end
		end
		aw_fire = i_awvalid && o_awready;
		if (aw_fire) wr_addr = i_aw.addr;
		w_fire = i_wvalid && o_wready;
		if (w_fire) begin
			wr_data = i_w.data;
			wr_strb = i_w.strb;
		end
		b_fire = o_bvalid && i_bready;
	endtask

	// everything changes on the falling edge
	initial begin
		clear_all();
		forever begin
			@(negedge aclk);
			if (!i_arst_n) clear_all();
			else step();
		end
	end

endmodule

`default_nettype wire

/* design/mem_frontend_top.sv */
`default_nettype none

module mem_frontend_top (
	input  wire                                 aclk,
	input  wire                                 i_arst_n,
	input  wire  mem_frontend_pkg::sram_req_t   i_inst_req,
	input  wire  mem_frontend_pkg::sram_req_t   i_data_req,
	input  wire                                 i_arready,
	input  wire                                 i_awready,
	input  wire                                 i_wready,
	input  wire  [mem_frontend_pkg::DATA_W-1:0] i_rdata,
	input  wire                                 i_rvalid,
	input  wire                                 i_bvalid,
	output logic [mem_frontend_pkg::DATA_W-1:0] o_inst_rdata,
	output logic [mem_frontend_pkg::DATA_W-1:0] o_data_rdata,
	output logic                                o_inst_stall,
	output logic                                o_data_stall,
	output logic                                o_inst_fault,
	output logic                                o_data_fault,
	output mem_frontend_pkg::axi_addr_t         o_ar,
	output logic                                o_arvalid,
	output logic                                o_rready,
	output mem_frontend_pkg::axi_addr_t         o_aw,
	output logic                                o_awvalid,
	output mem_frontend_pkg::axi_wdata_t        o_w,
	output logic                                o_wvalid,
	output logic                                o_bready
);

	wire mem_frontend_pkg::sram_req_t   core_req   [mem_frontend_pkg::N_PORTS];
	wire mem_frontend_pkg::sram_req_t   phys_req   [mem_frontend_pkg::N_PORTS];
	wire mem_frontend_pkg::bus_req_t    bus_req    [mem_frontend_pkg::N_PORTS];
	wire mem_frontend_pkg::bus_rsp_t    bus_rsp    [mem_frontend_pkg::N_PORTS];
	wire [mem_frontend_pkg::DATA_W-1:0] port_rdata [mem_frontend_pkg::N_PORTS];
	wire [mem_frontend_pkg::N_PORTS-1:0] port_stall;
	wire [mem_frontend_pkg::N_PORTS-1:0] fault;

	// ports are indexed in priority order
	assign core_req[mem_frontend_pkg::PORT_DATA] = i_data_req;
	assign core_req[mem_frontend_pkg::PORT_INST] = i_inst_req;

	assign o_data_rdata = port_rdata[mem_frontend_pkg::PORT_DATA];
	assign o_inst_rdata = port_rdata[mem_frontend_pkg::PORT_INST];
	assign o_data_stall = port_stall[mem_frontend_pkg::PORT_DATA];
	assign o_inst_stall = port_stall[mem_frontend_pkg::PORT_INST];
	assign o_data_fault = fault[mem_frontend_pkg::PORT_DATA];
	assign o_inst_fault = fault[mem_frontend_pkg::PORT_INST];

	seg_translate u_seg_translate (
		.i_req   (core_req),
		.o_phys  (phys_req),
		.o_fault (fault)
	);

	for (genvar p = 0; p < mem_frontend_pkg::N_PORTS; p++) begin : g_port
		uncached_port u_port (
			.aclk      (aclk),
			.i_arst_n  (i_arst_n),
			.i_req     (phys_req[p]),
			.i_fault   (fault[p]),
			.i_rsp     (bus_rsp[p]),
			.o_bus_req (bus_req[p]),
			.o_rdata   (port_rdata[p]),
			.o_stall   (port_stall[p])
		);
	end

	axi_arbiter_2x1 u_arbiter (
		.aclk      (aclk),
		.i_arst_n  (i_arst_n),
		.i_bus_req (bus_req),
		.i_arready (i_arready),
		.i_awready (i_awready),
		.i_wready  (i_wready),
		.i_rdata   (i_rdata),
		.i_rvalid  (i_rvalid),
		.i_bvalid  (i_bvalid),
		.o_bus_rsp (bus_rsp),
		.o_ar      (o_ar),
		.o_arvalid (o_arvalid),
		.o_rready  (o_rready),
		.o_aw      (o_aw),
		.o_awvalid (o_awvalid),
		.o_w       (o_w),
		.o_wvalid  (o_wvalid),
		.o_bready  (o_bready)
	);

endmodule

`default_nettype wire

/* design/axi_arbiter_2x1.sv */
`default_nettype none

module axi_arbiter_2x1 (
	input  wire                                 aclk,
	input  wire                                 i_arst_n,
	input  wire  mem_frontend_pkg::bus_req_t    i_bus_req [mem_frontend_pkg::N_PORTS],
	input  wire                                 i_arready,
	input  wire                                 i_awready,
	input  wire                                 i_wready,
	input  wire  [mem_frontend_pkg::DATA_W-1:0] i_rdata,
	input  wire                                 i_rvalid,
	input  wire                                 i_bvalid,
	output mem_frontend_pkg::bus_rsp_t          o_bus_rsp [mem_frontend_pkg::N_PORTS],
	output mem_frontend_pkg::axi_addr_t         o_ar,
	output logic                                o_arvalid,
	output logic                                o_rready,
	output mem_frontend_pkg::axi_addr_t         o_aw,
	output logic                                o_awvalid,
	output mem_frontend_pkg::axi_wdata_t        o_w,
	output logic                                o_wvalid,
	output logic                                o_bready
);

	mem_frontend_pkg::bus_state_e          state_q;
	mem_frontend_pkg::bus_state_e          state_d;
	logic [mem_frontend_pkg::PORT_W-1:0]   owner_q;
	logic [mem_frontend_pkg::PORT_W-1:0]   pick;
	logic                                  aw_done_q;
	logic                                  w_done_q;
	logic                                  aw_hs;
	logic                                  w_hs;
	logic                                  any_valid;
	logic                                  bus_done;
	mem_frontend_pkg::bus_req_t            cur;

	// fixed priority, data first
	assign any_valid = i_bus_req[mem_frontend_pkg::PORT_DATA].valid ||
	                   i_bus_req[mem_frontend_pkg::PORT_INST].valid;
	assign pick = i_bus_req[mem_frontend_pkg::PORT_DATA].valid ?
	              mem_frontend_pkg::PORT_DATA : mem_frontend_pkg::PORT_INST;
	assign cur  = i_bus_req[owner_q];  // port holds it stable while valid

	assign o_arvalid = (state_q == mem_frontend_pkg::RD_ADDR);
	assign o_rready  = (state_q == mem_frontend_pkg::RD_DATA);
	assign o_awvalid = (state_q == mem_frontend_pkg::WR_ADDR_DATA) && !aw_done_q;
	assign o_wvalid  = (state_q == mem_frontend_pkg::WR_ADDR_DATA) && !w_done_q;
	assign o_bready  = (state_q == mem_frontend_pkg::WR_RESP);

	assign aw_hs    = o_awvalid && i_awready;
	assign w_hs     = o_wvalid && i_wready;
	assign bus_done = (o_rready && i_rvalid) || (o_bready && i_bvalid);

	assign o_ar.addr = cur.addr;
	assign o_ar.size = {1'b0, cur.size};
	assign o_aw      = o_ar;
	assign o_w.data  = cur.wdata;
	assign o_w.strb  = cur.wstrb;

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_frontend_pkg::BUS_IDLE: begin
				if (any_valid) begin
					state_d = i_bus_req[pick].write ? mem_frontend_pkg::WR_ADDR_DATA :
					                                  mem_frontend_pkg::RD_ADDR;
				end
			end
			mem_frontend_pkg::RD_ADDR: begin
				if (i_arready) begin
					state_d = mem_frontend_pkg::RD_DATA;
				end
			end
			mem_frontend_pkg::RD_DATA: begin
				if (i_rvalid) begin
					state_d = mem_frontend_pkg::BUS_IDLE;
				end
			end
			mem_frontend_pkg::WR_ADDR_DATA: begin
				// aw and w may complete in either order
				if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
					state_d = mem_frontend_pkg::WR_RESP;
				end
			end
			mem_frontend_pkg::WR_RESP: begin
				if (i_bvalid) begin
					state_d = mem_frontend_pkg::BUS_IDLE;
				end
			end
			default: state_d = mem_frontend_pkg::BUS_IDLE;
		endcase
	end

	always_ff @(posedge aclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q   <= mem_frontend_pkg::BUS_IDLE;
			owner_q   <= mem_frontend_pkg::PORT_DATA;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if ((state_q == mem_frontend_pkg::BUS_IDLE) && any_valid) begin
				owner_q <= pick;
			end
			if ((state_q == mem_frontend_pkg::WR_ADDR_DATA) &&
			    (state_d == mem_frontend_pkg::WR_ADDR_DATA)) begin
				aw_done_q <= aw_done_q || aw_hs;
				w_done_q  <= w_done_q || w_hs;
			end else begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end
		end
	end

	// response only to the port that owns the bus
	always_comb begin
		for (int p = 0; p < mem_frontend_pkg::N_PORTS; p++) begin
			o_bus_rsp[p].done  = bus_done && (owner_q == mem_frontend_pkg::PORT_W'(p));
			o_bus_rsp[p].rdata = (owner_q == mem_frontend_pkg::PORT_W'(p)) ? i_rdata : '0;
		end
	end

endmodule

`default_nettype wire

/* design/uncached_port.sv */
`default_nettype none

module uncached_port (
	input  wire                                 aclk,
	input  wire                                 i_arst_n,
	input  wire  mem_frontend_pkg::sram_req_t   i_req,    // already translated
	input  wire                                 i_fault,
	input  wire  mem_frontend_pkg::bus_rsp_t    i_rsp,
	output mem_frontend_pkg::bus_req_t          o_bus_req,
	output logic [mem_frontend_pkg::DATA_W-1:0] o_rdata,
	output logic                                o_stall
);

	mem_frontend_pkg::port_state_e state_q;
	mem_frontend_pkg::port_state_e state_d;
	mem_frontend_pkg::bus_req_t    hold_q;
	logic                          accept;
	logic                          finish;

	// faulting requests never leave IDLE
	assign accept = (state_q == mem_frontend_pkg::IDLE) && i_req.en && !i_fault;
	assign finish = (state_q == mem_frontend_pkg::WAIT) && i_rsp.done;

	// stall rises in the accept cycle and drops for the single DONE cycle
	assign o_stall = accept || (state_q == mem_frontend_pkg::WAIT);

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_frontend_pkg::IDLE: begin
				if (accept) begin
					state_d = mem_frontend_pkg::WAIT;
				end
			end
			mem_frontend_pkg::WAIT: begin
				if (i_rsp.done) begin
					state_d = mem_frontend_pkg::DONE;
				end
			end
			mem_frontend_pkg::DONE: state_d = mem_frontend_pkg::IDLE;
			default:                state_d = mem_frontend_pkg::IDLE;
		endcase
	end

	always_ff @(posedge aclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= mem_frontend_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// request snapshot held while the bus works on it
	always_ff @(posedge aclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			hold_q <= '0;
		end else if (accept) begin
			hold_q.valid <= 1'b1;
			hold_q.write <= |i_req.wen;
			hold_q.addr  <= i_req.addr;
			hold_q.size  <= i_req.size;
			hold_q.wdata <= i_req.wdata;
			hold_q.wstrb <= i_req.wen;
		end else if (finish) begin
			hold_q.valid <= 1'b0;  // done pulse ends the request
		end
	end

	always_ff @(posedge aclk) begin
		if (finish) begin
			o_rdata <= i_rsp.rdata;  // held through DONE
		end
	end

	assign o_bus_req = hold_q;

endmodule

`default_nettype wire

/* design/seg_translate.sv */
`default_nettype none

module seg_translate (
	input  wire  mem_frontend_pkg::sram_req_t i_req  [mem_frontend_pkg::N_PORTS],
	output mem_frontend_pkg::sram_req_t       o_phys [mem_frontend_pkg::N_PORTS],
	output logic [mem_frontend_pkg::N_PORTS-1:0] o_fault
);

	function automatic logic in_kseg(input logic [mem_frontend_pkg::ADDR_W-1:0] addr);
		return (addr >= mem_frontend_pkg::KSEG_BASE) && (addr <= mem_frontend_pkg::KSEG_TOP);
	endfunction

	// low address bits must be zero for the access size
	function automatic logic misaligned(
		input mem_frontend_pkg::size_e             size,
		input logic [mem_frontend_pkg::ADDR_W-1:0] addr
	);
		case (size)
			mem_frontend_pkg::SIZE_HALF: return addr[0];
			mem_frontend_pkg::SIZE_WORD: return |addr[1:0];
			default:                     return 1'b0;  // bytes never fault
		endcase
	endfunction

	always_comb begin
		for (int p = 0; p < mem_frontend_pkg::N_PORTS; p++) begin
			o_phys[p] = i_req[p];
			if (in_kseg(i_req[p].addr)) begin
				// kseg0/kseg1 map straight onto the low 512M
				o_phys[p].addr[mem_frontend_pkg::ADDR_W-1 -: mem_frontend_pkg::SEG_MASK_BITS] = '0;
			end
			o_fault[p] = i_req[p].en && misaligned(i_req[p].size, i_req[p].addr);
		end
	end

endmodule

`default_nettype wire

/* design/mem_frontend_pkg.sv */
`default_nettype none

package mem_frontend_pkg;

	localparam int unsigned ADDR_W        = 32;
	localparam int unsigned DATA_W        = 32;
	localparam int unsigned STRB_W        = 4;
	localparam int unsigned N_PORTS       = 2;
	localparam int unsigned PORT_W        = $clog2(N_PORTS);
	localparam int unsigned SEG_MASK_BITS = 3;

	// data side wins arbitration
	localparam logic [PORT_W-1:0] PORT_DATA = 0;
	localparam logic [PORT_W-1:0] PORT_INST = 1;

	// kseg0 and kseg1, unmapped
	localparam logic [ADDR_W-1:0] KSEG_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] KSEG_TOP  = 32'hbfff_ffff;

	// same encoding as AXI axsize
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} size_e;

	typedef struct packed {
		logic              en;
		logic [STRB_W-1:0] wen;  // all zero for a read
		size_e             size;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} sram_req_t;

	typedef struct packed {
		logic              valid;
		logic              write;
		logic [ADDR_W-1:0] addr;   // physical
		size_e             size;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} bus_req_t;

	typedef struct packed {
		logic              done;  // one cycle
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	// shared by AR and AW
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        size;
	} axi_addr_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_wdata_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		DONE
	} port_state_e;

	typedef enum logic [2:0] {
		BUS_IDLE,
		RD_ADDR,
		RD_DATA,
		WR_ADDR_DATA,
		WR_RESP
	} bus_state_e;

endpackage

`default_nettype wire
